/* src/ls_pkg.sv */
package ls_pkg;

    // data path width
    localparam int XLEN = 64;

    // major opcode in instr[6:2]
    typedef enum logic [4:0] {
        OPC_LOAD  = 5'b00000,
        OPC_STORE = 5'b01000
    } ls_opcode_e;

    // access width from funct3
    // only the first four apply to stores
    typedef enum logic [2:0] {
        MW_B  = 3'b000,
        MW_H  = 3'b001,
        MW_W  = 3'b010,
        MW_D  = 3'b011,
        MW_BU = 3'b100,
        MW_HU = 3'b101,
        MW_WU = 3'b110
    } mem_width_e;

    // what a pipeline slot carries
    typedef enum logic [1:0] {
        LS_NONE  = 2'd0,
        LS_LOAD  = 2'd1,
        LS_STORE = 2'd2
    } ls_kind_e;

endpackage

/* src/ls_decode.sv */
module ls_decode import ls_pkg::*; #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic                          valid_i,
    input  logic [31:0]                   instr_i,
    input  logic [XLEN-1:0]               addr_i,
    input  logic [XLEN-1:0]               store_data_i,
    output logic                          rd_en_o,
    output logic [$clog2(DMEM_WORDS)-1:0] rd_index_o,
    output ls_kind_e                      b_kind_o,
    output mem_width_e                    b_width_o,
    output logic [2:0]                    b_offset_o,
    output logic [$clog2(DMEM_WORDS)-1:0] b_index_o,
    output logic [XLEN-1:0]               b_store_data_o
);

    ls_opcode_e opcode;
    ls_kind_e   kind;

    assign opcode = ls_opcode_e'(instr_i[6:2]);

    // anything that is not a load or store is dropped here
    always_comb begin
        kind = LS_NONE;
        if (valid_i) begin
            case (opcode)
                OPC_LOAD:  kind = LS_LOAD;
                OPC_STORE: kind = LS_STORE;
                default:   kind = LS_NONE;
            endcase
        end
    end

    // stores read too, the merge needs the old word
    assign rd_en_o    = (kind != LS_NONE);
    assign rd_index_o = addr_i[3 +: $clog2(DMEM_WORDS)];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            b_kind_o <= LS_NONE;
        end else begin
            b_kind_o <= kind;
        end
    end

    // payload fields for stage B
    always_ff @(posedge clk) begin
        b_width_o      <= mem_width_e'(instr_i[14:12]);
        b_offset_o     <= addr_i[2:0];
        b_index_o      <= addr_i[3 +: $clog2(DMEM_WORDS)];
        b_store_data_o <= store_data_i;
    end

endmodule

/* src/ls_dmem.sv */
module ls_dmem import ls_pkg::*; #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                          clk,
    input  logic                          rd_en_i,
    input  logic [$clog2(DMEM_WORDS)-1:0] rd_index_i,
    output logic [XLEN-1:0]               rd_word_o,
    input  logic                          wr_en_i,
    input  logic [$clog2(DMEM_WORDS)-1:0] wr_index_i,
    input  logic [XLEN-1:0]               wr_word_i
);

    logic [XLEN-1:0] mem [DMEM_WORDS];

    // registered read port
    // a write to the same index at this edge is not seen
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_word_o <= mem[rd_index_i];
        end
    end

    // write port
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_index_i] <= wr_word_i;
        end
    end

endmodule

/* src/ls_store_merge.sv */
module ls_store_merge import ls_pkg::*; #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                          clk,
    input  logic                          rst_i,
    input  ls_kind_e                      kind_i,
    input  mem_width_e                    width_i,
    input  logic [2:0]                    offset_i,
    input  logic [$clog2(DMEM_WORDS)-1:0] index_i,
    input  logic [XLEN-1:0]               store_data_i,
    input  logic [XLEN-1:0]               rd_word_i,
    output logic                          wr_en_o,
    output logic [$clog2(DMEM_WORDS)-1:0] wr_index_o,
    output logic [XLEN-1:0]               wr_word_o,
    output logic [XLEN-1:0]               base_word_o
);

    logic                          is_store;
    logic                          use_fwd;
    logic [XLEN-1:0]               base_word;
    logic [XLEN-1:0]               merged_word;

    // last store bypass
    logic                          fwd_valid;
    logic [$clog2(DMEM_WORDS)-1:0] fwd_index;
    logic [XLEN-1:0]               fwd_word;

    assign is_store = (kind_i == LS_STORE);

    // the RAM returned stale data when the previous cycle wrote this word
    assign use_fwd   = fwd_valid && (fwd_index == index_i);
    assign base_word = use_fwd ? fwd_word : rd_word_i;

    // drop the store data into its lane, keep the rest of the word
    always_comb begin
        merged_word = base_word;
        case (width_i)
            MW_B: begin
                merged_word[{offset_i, 3'b000} +: 8] = store_data_i[7:0];
            end
            MW_H: begin
                merged_word[{offset_i[2:1], 4'b0000} +: 16] = store_data_i[15:0];
            end
            MW_W: begin
                merged_word[{offset_i[2], 5'b00000} +: 32] = store_data_i[31:0];
            end
            MW_D: begin
                merged_word = store_data_i;
            end
            // unsigned widths have no store form, word is written back as is
            default: begin
                merged_word = base_word;
            end
        endcase
    end

    assign wr_en_o     = is_store;
    assign wr_index_o  = index_i;
    assign wr_word_o   = merged_word;
    assign base_word_o = base_word;

    // flag lives for exactly one cycle after a store
    always_ff @(posedge clk) begin
        if (rst_i) begin
            fwd_valid <= 1'b0;
        end else begin
            fwd_valid <= is_store;
        end
    end

    always_ff @(posedge clk) begin
        if (is_store) begin
            fwd_index <= index_i;
            fwd_word  <= merged_word;
        end
    end

endmodule

/* src/ls_load_extract.sv */
module ls_load_extract import ls_pkg::*; (
    input  logic            clk,
    input  logic            rst_i,
    input  ls_kind_e        kind_i,
    input  mem_width_e      width_i,
    input  logic [2:0]      offset_i,
    input  logic [XLEN-1:0] base_word_i,
    output logic            load_valid_o,
    output logic [XLEN-1:0] load_data_o
);

    logic [7:0]      byte_sel;
    logic [15:0]     half_sel;
    logic [31:0]     word_sel;
    logic [XLEN-1:0] load_result;
    logic            is_load;

    assign is_load = (kind_i == LS_LOAD);

    // low offset bits beyond the access size are ignored
    assign byte_sel = base_word_i[{offset_i, 3'b000} +: 8];
    assign half_sel = base_word_i[{offset_i[2:1], 4'b0000} +: 16];
    assign word_sel = base_word_i[{offset_i[2], 5'b00000} +: 32];

    // sign or zero extend to XLEN
    always_comb begin
        case (width_i)
            MW_B: begin
                load_result = {{(XLEN-8){byte_sel[7]}}, byte_sel};
            end
            MW_H: begin
                load_result = {{(XLEN-16){half_sel[15]}}, half_sel};
            end
            MW_W: begin
                load_result = {{(XLEN-32){word_sel[31]}}, word_sel};
            end
            MW_D: begin
                load_result = base_word_i;
            end
            MW_BU: begin
                load_result = {{(XLEN-8){1'b0}}, byte_sel};
            end
            MW_HU: begin
                load_result = {{(XLEN-16){1'b0}}, half_sel};
            end
            MW_WU: begin
                load_result = {{(XLEN-32){1'b0}}, word_sel};
            end
            // funct3 111 is not a load width
            default: begin
                load_result = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            load_valid_o <= 1'b0;
        end else begin
            load_valid_o <= is_load;
        end
    end

    // hold the last result between loads
    always_ff @(posedge clk) begin
        if (is_load) begin
            load_data_o <= load_result;
        end
    end

endmodule

/* src/ls_stage.sv */
module ls_stage import ls_pkg::*; #(
    parameter int DMEM_WORDS = 256
) (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            valid_i,
    input  logic [31:0]     instr_i,
    input  logic [XLEN-1:0] addr_i,
    input  logic [XLEN-1:0] store_data_i,
    output logic            load_valid_o,
    output logic [XLEN-1:0] load_data_o
);

    // stage A to RAM
    logic                          rd_en;
    logic [$clog2(DMEM_WORDS)-1:0] rd_index;
    logic [XLEN-1:0]               rd_word;

    // stage B fields
    ls_kind_e                      b_kind;
    mem_width_e                    b_width;
    logic [2:0]                    b_offset;
    logic [$clog2(DMEM_WORDS)-1:0] b_index;
    logic [XLEN-1:0]               b_store_data;

    // write back and load path
    logic                          wr_en;
    logic [$clog2(DMEM_WORDS)-1:0] wr_index;
    logic [XLEN-1:0]               wr_word;
    logic [XLEN-1:0]               base_word;

    ls_decode #(
        .DMEM_WORDS     (DMEM_WORDS)
    ) u_decode (
        .clk            (clk),
        .rst_i          (rst_i),
        .valid_i        (valid_i),
        .instr_i        (instr_i),
        .addr_i         (addr_i),
        .store_data_i   (store_data_i),
        .rd_en_o        (rd_en),
        .rd_index_o     (rd_index),
        .b_kind_o       (b_kind),
        .b_width_o      (b_width),
        .b_offset_o     (b_offset),
        .b_index_o      (b_index),
        .b_store_data_o (b_store_data)
    );

    ls_dmem #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_dmem (
        .clk        (clk),
        .rd_en_i    (rd_en),
        .rd_index_i (rd_index),
        .rd_word_o  (rd_word),
        .wr_en_i    (wr_en),
        .wr_index_i (wr_index),
        .wr_word_i  (wr_word)
    );

    ls_store_merge #(
        .DMEM_WORDS   (DMEM_WORDS)
    ) u_store_merge (
        .clk          (clk),
        .rst_i        (rst_i),
        .kind_i       (b_kind),
        .width_i      (b_width),
        .offset_i     (b_offset),
        .index_i      (b_index),
        .store_data_i (b_store_data),
        .rd_word_i    (rd_word),
        .wr_en_o      (wr_en),
        .wr_index_o   (wr_index),
        .wr_word_o    (wr_word),
        .base_word_o  (base_word)
    );

    // result register sits at the end of stage B
    ls_load_extract u_load_extract (
        .clk          (clk),
        .rst_i        (rst_i),
        .kind_i       (b_kind),
        .width_i      (b_width),
        .offset_i     (b_offset),
        .base_word_i  (base_word),
        .load_valid_o (load_valid_o),
        .load_data_o  (load_data_o)
    );

endmodule

/* tests/tb_ls_model.svh */
`ifndef TB_LS_MODEL_SVH
`define TB_LS_MODEL_SVH

// reference memory, updated in issue order
logic [XLEN-1:0] model_mem [MEM_WORDS];
int err_cnt = 0;

// byte mask for an access of size bytes
function automatic logic [XLEN-1:0] size_mask(input int size);
    if (size == 8) begin
        return '1;
    end
    return (64'd1 << (8 * size)) - 64'd1;
endfunction

// expected result of a load with funct3 f3 at addr
function automatic logic [XLEN-1:0] expect_load(input logic [2:0] f3,
                                                input logic [XLEN-1:0] addr);
    logic [XLEN-1:0] mask;
    logic [XLEN-1:0] field;
    int size;
    int shift;
    if (f3 == 3'b111) begin
        return '0;
    end
    size  = 1 << f3[1:0];
    // align the offset down to the access size
    shift = 8 * (int'(addr[2:0]) / size * size);
    mask  = size_mask(size);
    field = (model_mem[addr[10:3]] >> shift) & mask;
    // funct3 bit 2 selects zero extension
    if (!f3[2] && size < 8 && field[8 * size - 1]) begin
        field = field | ~mask;
    end
    return field;
endfunction

function automatic void apply_store(input logic [2:0] f3, input logic [XLEN-1:0] addr,
                                    input logic [XLEN-1:0] data);
    logic [XLEN-1:0] mask;
    int size;
    int shift;
    size  = 1 << f3[1:0];
    shift = 8 * (int'(addr[2:0]) / size * size);
    mask  = size_mask(size);
    model_mem[addr[10:3]] = (model_mem[addr[10:3]] & ~(mask << shift)) |
                            ((data & mask) << shift);
endfunction

task automatic check_data(input string sig, input logic [XLEN-1:0] expected,
                          input logic [XLEN-1:0] actual);
    if (actual !== expected) begin
        $display("FAILED t=%0t %s expected %h got %h", $time, sig, expected, actual);
        err_cnt++;
    end
endtask

task automatic check_count(input string sig, input int expected, input int actual);
    if (actual != expected) begin
        $display("FAILED t=%0t %s expected %0d got %0d", $time, sig, expected, actual);
        err_cnt++;
    end
endtask

`endif

/* tests/tb_ls_stage.sv */
module tb_ls_stage
    import ls_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_WORDS   = 256;
    localparam int DRAIN_LIMIT = 20;

    logic            clk = 1'b0;
    logic            rst_i;
    logic            valid_i;
    logic [31:0]     instr_i;
    logic [XLEN-1:0] addr_i;
    logic [XLEN-1:0] store_data_i;
    logic            load_valid_o;
    logic [XLEN-1:0] load_data_o;

    `include "tb_ls_model.svh"

    // expected load results and their issue cycles, oldest first
    logic [XLEN-1:0] exp_q[$];
    int              issue_q[$];

    logic [15:0]     lfsr_state = 16'd28933;
    logic [XLEN-1:0] exp_word;
    int              exp_cyc;
    int cycle_cnt    = 0;
    int pulse_cnt    = 0;
    int loads_issued = 0;
    int err_start;
    int pulse_start;
    int loads_start;
    int tests_passed = 0;
    int tests_failed = 0;

    ls_stage #(
        .DMEM_WORDS   (MEM_WORDS)
    ) UUT (
        .clk          (clk),
        .rst_i        (rst_i),
        .valid_i      (valid_i),
        .instr_i      (instr_i),
        .addr_i       (addr_i),
        .store_data_i (store_data_i),
        .load_valid_o (load_valid_o),
        .load_data_o  (load_data_o)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // random filler in the fields the stage does not decode
    function automatic logic [31:0] make_instr(input logic [4:0] opc, input logic [2:0] f3);
        logic [63:0] r;
        logic [31:0] w;
        r = rand_bits(32);
        w = r[31:0];
        w[1:0]   = 2'b11;
        w[6:2]   = opc;
        w[14:12] = f3;
        return w;
    endfunction

    function automatic logic [XLEN-1:0] make_addr(input logic [7:0] idx, input logic [2:0] off);
        logic [63:0] r;
        r = rand_bits(53);
        return {r[52:0], idx, off};
    endfunction

    task automatic issue(input ls_kind_e kind, input logic v, input logic [31:0] instr,
                         input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data);
        @(posedge clk);
        valid_i      <= v;
        instr_i      <= instr;
        addr_i       <= addr;
        store_data_i <= data;
        if (v && kind == LS_LOAD) begin
            exp_q.push_back(expect_load(instr[14:12], addr));
            // the counter moves to the next value at this same edge
            issue_q.push_back(cycle_cnt + 1);
            loads_issued++;
        end else if (v && kind == LS_STORE) begin
            apply_store(instr[14:12], addr, data);
        end
    endtask

    task automatic do_load(input logic [7:0] idx, input logic [2:0] off, input logic [2:0] f3);
        issue(LS_LOAD, 1'b1, make_instr(OPC_LOAD, f3), make_addr(idx, off), '0);
    endtask

    task automatic do_store(input logic [7:0] idx, input logic [2:0] off, input logic [2:0] f3,
                            input logic [XLEN-1:0] data);
        issue(LS_STORE, 1'b1, make_instr(OPC_STORE, f3), make_addr(idx, off), data);
    endtask

    // valid low while the word looks like a store
    task automatic do_idle();
        issue(LS_NONE, 1'b0, make_instr(OPC_STORE, 3'b011), make_addr(8'd0, 3'd0), '1);
    endtask

    task automatic do_other();
        logic [63:0] r;
        logic [4:0]  opc;
        r   = rand_bits(5);
        opc = r[4:0];
        if (opc == OPC_LOAD || opc == OPC_STORE) begin
            opc = opc ^ 5'b00100;
        end
        issue(LS_NONE, 1'b1, make_instr(opc, 3'b011), make_addr(8'd0, 3'd0), '1);
    endtask

    task automatic start_test();
        err_start   = err_cnt;
        pulse_start = pulse_cnt;
        loads_start = loads_issued;
    endtask

    task automatic finish_test(input string name);
        int t;
        t = 0;
        while (exp_q.size() != 0 && t < DRAIN_LIMIT) begin
            do_idle();
            t++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout in %s: %0d loads never produced load_valid_o", name, exp_q.size());
            $display("TEST FAILED");
            $finish;
        end else begin
            // a few quiet cycles to catch stray pulses
            repeat (3) do_idle();
            check_count("load_valid_o pulses", loads_issued - loads_start,
                        pulse_cnt - pulse_start);
            if (err_cnt == err_start) begin
                tests_passed++;
            end else begin
                tests_failed++;
            end
            $display("[%0t] %s: %0d loads, %0d errors", $time, name,
                     loads_issued - loads_start, err_cnt - err_start);
        end
    endtask

    // result monitor away from the driving edge
    always @(negedge clk) begin
        if (load_valid_o === 1'b1) begin
            pulse_cnt++;
            if (exp_q.size() == 0) begin
                $display("ERROR t=%0t load_valid_o pulsed with no load outstanding", $time);
                err_cnt++;
            end else begin
                exp_word = exp_q.pop_front();
                exp_cyc  = issue_q.pop_front();
                check_data("load_data_o", exp_word, load_data_o);
                check_count("load latency", 2, cycle_cnt - exp_cyc);
            end
        end
    end

    initial begin
        logic [63:0] r;
        logic [63:0] d;
        logic [7:0]  idx;
        logic [7:0]  idx2;
        logic [2:0]  f3;

        rst_i        <= 1'b1;
        valid_i      <= 1'b0;
        instr_i      <= '0;
        addr_i       <= '0;
        store_data_i <= '0;
        repeat (4) @(posedge clk);
        rst_i <= 1'b0;

        start_test();
        for (int i = 0; i < MEM_WORDS; i++) begin
            r = rand_bits(3);
            d = rand_bits(64);
            do_store(i[7:0], r[2:0], 3'b011, d);
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            r = rand_bits(3);
            do_load(i[7:0], r[2:0], 3'b011);
        end
        finish_test("fill and readback");

        // byte, half and word loads, no ld and no 111
        start_test();
        for (int i = 0; i < 300; i++) begin
            r  = rand_bits(14);
            f3 = r[2:0];
            if (f3[1:0] == 2'b11) begin
                f3 = f3 ^ 3'b001;
            end
            do_load(r[13:6], r[5:3], f3);
        end
        finish_test("sub-word loads");

        start_test();
        for (int i = 0; i < 200; i++) begin
            r  = rand_bits(13);
            d  = rand_bits(64);
            f3 = (r[1:0] == 2'b11) ? 3'b010 : {1'b0, r[1:0]};
            do_store(r[12:5], r[4:2], f3, d);
            do_idle();
            do_load(r[12:5], 3'd0, 3'b011);
        end
        finish_test("sub-word stores");

        // store then an access in the very next cycle
        start_test();
        for (int i = 0; i < 200; i++) begin
            r    = rand_bits(24);
            d    = rand_bits(64);
            idx  = r[7:0];
            idx2 = r[8] ? idx : idx ^ {r[15:9], 1'b1};
            do_store(idx, r[18:16], {1'b0, r[20:19]}, d);
            if (r[21]) begin
                do_load(idx2, r[18:16], {r[23:22], 1'b0});
            end else begin
                d = rand_bits(64);
                do_store(idx2, r[23:21], {1'b0, r[20:19]}, d);
                do_load(idx2, 3'd0, 3'b011);
            end
            do_load(idx, 3'd0, 3'b011);
        end
        finish_test("store forwarding");

        start_test();
        for (int i = 0; i < 200; i++) begin
            r = rand_bits(1);
            if (r[0]) begin
                do_idle();
            end else begin
                do_other();
            end
        end
        repeat (3) do_idle();
        check_count("load_valid_o pulses", 0, pulse_cnt - pulse_start);
        // idle and other cycles all aim at word 0
        do_load(8'd0, 3'd0, 3'b011);
        for (int i = 0; i < 32; i++) begin
            r = rand_bits(8);
            do_load(r[7:0], 3'd0, 3'b011);
        end
        finish_test("no-effect cycles");

        // small index range half the time to hit the bypass often
        start_test();
        for (int i = 0; i < 2000; i++) begin
            r   = rand_bits(18);
            d   = rand_bits(64);
            idx = r[2] ? r[10:3] : {5'b00000, r[5:3]};
            case (r[1:0])
                2'b00, 2'b01: do_load(idx, r[13:11], r[16:14]);
                2'b10:        do_store(idx, r[13:11], {1'b0, r[15:14]}, d);
                default: begin
                    if (r[17]) begin
                        do_idle();
                    end else begin
                        do_other();
                    end
                end
            endcase
        end
        finish_test("random mix");

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && err_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+tests
src/ls_pkg.sv
src/ls_decode.sv
src/ls_dmem.sv
src/ls_store_merge.sv
src/ls_load_extract.sv
src/ls_stage.sv
tests/tb_ls_stage.sv

/* run.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f build.f --top-module tb_ls_stage \
    -Mdir obj_dir -o tb_ls_stage_sim
if [ $? -ne 0 ]; then
    echo "verilator compile step failed"
    exit 1
fi

./obj_dir/tb_ls_stage_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST OK" "$LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation did not pass, see $LOG"
exit 1
